// ==== compile.f ====
hw/npc_pkg.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/data_mem.sv
hw/npc.sv
verif/npc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= npc_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/npc_tb.sv ====
module npc_tb;
    import npc_pkg::*;

    localparam logic [31:0] reset_pc = 32'h8000_0000;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    logic        clk;
    logic        reset;
    logic        run;
    logic        prog_we;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic        halted;
    commit_t     commit;

    // program image, also fetched by the model
    logic [31:0] prog [$];
    logic [31:0] lcg_state = 32'd2;
    // instruction-set model state
    logic [31:0] m_regs [32];
    logic [31:0] m_dmem [256];
    logic [31:0] m_pc = reset_pc;
    int          errors = 0;
    int          checks = 0;
    int          n_commits = 0;
    int          ebreak_count = 0;
    int          cycles = 0;
    int          limit = 0;
    logic        after_ebreak = 1'b0;

    npc #(
        .RESET_PC   (reset_pc),
        .IMEM_WORDS (256),
        .DMEM_WORDS (256)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .halted    (halted),
        .commit    (commit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // encoders, imm holds the field value before slicing
    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input int opc, input int f3, input int rd,
                                           input int rs1, input logic [31:0] imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_type(input int f3, input int rs1, input int rs2,
                                           input logic [31:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input logic [31:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    // upper holds the 20-bit field
    function automatic logic [31:0] u_type(input int opc, input int rd, input logic [31:0] upper);
        return {upper[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic build_program();
        logic [31:0] v;
        logic [31:0] w;
        int kind;
        int rd;
        int rs1;
        int rs2;
        // every register gets a defined value first
        for (int r = 1; r < 32; r++) begin
            v = lcg_next();
            prog.push_back(u_type('h37, r, v >> 12));
        end
        // random register and immediate alu ops
        for (int n = 0; n < 60; n++) begin
            v = lcg_next();
            w = lcg_next();
            rd = int'((v >> 8) % 32);
            rs1 = int'((v >> 13) % 32);
            rs2 = int'((v >> 18) % 32);
            kind = int'((v >> 23) % 12);
            case (kind)
                0: prog.push_back(r_type(0, 0, rd, rs1, rs2));
                1: prog.push_back(r_type('h20, 0, rd, rs1, rs2));
                2: prog.push_back(r_type(0, 4, rd, rs1, rs2));
                3: prog.push_back(r_type(0, 6, rd, rs1, rs2));
                4: prog.push_back(r_type(0, 7, rd, rs1, rs2));
                5: prog.push_back(r_type(0, 1, rd, rs1, rs2));
                6: prog.push_back(r_type(0, 3, rd, rs1, rs2));
                7: prog.push_back(i_type('h13, 0, rd, rs1, w >> 16));
                8: prog.push_back(i_type('h13, 4, rd, rs1, w >> 16));
                9: prog.push_back(i_type('h13, 7, rd, rs1, w >> 16));
                10: prog.push_back(i_type('h13, 3, rd, rs1, w >> 16));
                // srai, funct7 0x20 sits in imm[11:5]
                default: prog.push_back(i_type('h13, 5, rd, rs1, 32'h400 | ((w >> 16) % 32)));
            endcase
        end
        // stores then loads around 0x100
        prog.push_back(i_type('h13, 0, 10, 0, 256));
        prog.push_back(u_type('h37, 11, 'h12345));
        prog.push_back(i_type('h13, 0, 11, 11, 'h678));
        prog.push_back(i_type('h13, 0, 12, 0, -85));
        prog.push_back(i_type('h13, 0, 13, 0, -292));
        prog.push_back(s_type(2, 10, 11, 0));
        prog.push_back(s_type(1, 10, 13, 2));
        prog.push_back(s_type(0, 10, 12, 1));
        prog.push_back(s_type(2, 10, 11, 4));
        prog.push_back(s_type(0, 10, 12, 7));
        prog.push_back(i_type('h03, 2, 14, 10, 0));
        prog.push_back(i_type('h03, 4, 15, 10, 1));
        prog.push_back(i_type('h03, 4, 16, 10, 7));
        prog.push_back(i_type('h03, 2, 17, 10, 4));
        // taken branches skip a marker write to x20
        prog.push_back(b_type(0, 14, 14, 8));
        prog.push_back(i_type('h13, 0, 20, 0, 1));
        prog.push_back(b_type(1, 14, 14, 8));
        prog.push_back(b_type(1, 14, 15, 8));
        prog.push_back(i_type('h13, 0, 20, 0, 2));
        prog.push_back(b_type(5, 12, 0, 8));
        prog.push_back(b_type(5, 0, 12, 8));
        prog.push_back(i_type('h13, 0, 20, 0, 3));
        prog.push_back(b_type(0, 15, 14, 8));
        // jal skips one, jalr target is odd so bit 0 must clear
        prog.push_back(j_type(1, 8));
        prog.push_back(i_type('h13, 0, 20, 0, 4));
        prog.push_back(u_type('h17, 21, 0));
        prog.push_back(i_type('h67, 0, 22, 21, 13));
        prog.push_back(i_type('h13, 0, 20, 0, 5));
        prog.push_back(u_type('h37, 23, 'habcde));
        prog.push_back(u_type('h17, 24, 'h12345));
        // x0 write must vanish
        prog.push_back(i_type('h13, 0, 0, 0, 5));
        prog.push_back(r_type(0, 0, 25, 0, 0));
        prog.push_back(i_type('h13, 5, 26, 12, 'h403));
        prog.push_back(r_type('h20, 0, 27, 0, 11));
        prog.push_back(r_type(0, 3, 28, 0, 11));
        prog.push_back(ebreak_word);
    endtask

    // retires the instruction at m_pc, returns its trace
    function automatic commit_t step_model();
        commit_t     c;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] wd;
        logic [31:0] w;
        logic [31:0] next;
        logic [3:0]  mask;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wen;
        logic        taken;
        int          idx;
        idx = int'((m_pc - reset_pc) >> 2);
        inst = prog[idx];
        a = m_regs[inst[19:15]];
        b = m_regs[inst[24:20]];
        rd = inst[11:7];
        f3 = inst[14:12];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        c = '0;
        c.valid = 1'b1;
        c.pc = m_pc;
        c.inst = inst;
        next = m_pc + 32'd4;
        wen = 1'b0;
        w = 32'd0;
        case (inst[6:0])
            7'h37: begin
                wen = 1'b1;
                w = {inst[31:12], 12'b0};
            end
            7'h17: begin
                wen = 1'b1;
                w = m_pc + {inst[31:12], 12'b0};
            end
            7'h6f: begin
                wen = 1'b1;
                w = m_pc + 32'd4;
                next = m_pc + imm_j;
            end
            7'h67: begin
                wen = 1'b1;
                w = m_pc + 32'd4;
                next = (a + imm_i) & ~32'd1;
            end
            7'h33: begin
                wen = 1'b1;
                case ({inst[30], f3})
                    4'b0000: w = a + b;
                    4'b1000: w = a - b;
                    4'b0100: w = a ^ b;
                    4'b0110: w = a | b;
                    4'b0111: w = a & b;
                    4'b0001: w = a << b[4:0];
                    default: w = (a < b) ? 32'd1 : 32'd0;
                endcase
            end
            7'h13: begin
                wen = 1'b1;
                case (f3)
                    3'b000: w = a + imm_i;
                    3'b100: w = a ^ imm_i;
                    3'b111: w = a & imm_i;
                    3'b011: w = (a < imm_i) ? 32'd1 : 32'd0;
                    default: w = $unsigned($signed(a) >>> inst[24:20]);
                endcase
            end
            7'h03: begin
                wen = 1'b1;
                addr = a + imm_i;
                word = m_dmem[addr[9:2]];
                w = (f3 == 3'b100) ? {24'b0, word[8*addr[1:0] +: 8]} : word;
            end
            7'h23: begin
                addr = a + imm_s;
                case (f3)
                    3'b000: begin
                        mask = 4'b0001 << addr[1:0];
                        wd = {24'b0, b[7:0]} << (8 * addr[1:0]);
                    end
                    3'b001: begin
                        mask = addr[1] ? 4'b1100 : 4'b0011;
                        wd = addr[1] ? {b[15:0], 16'b0} : {16'b0, b[15:0]};
                    end
                    default: begin
                        mask = 4'b1111;
                        wd = b;
                    end
                endcase
                for (int i = 0; i < 4; i++) begin
                    if (mask[i]) begin
                        m_dmem[addr[9:2]][8*i +: 8] = wd[8*i +: 8];
                    end
                end
                c.mem_wen = 1'b1;
                c.mem_addr = addr;
                c.mem_wdata = wd;
                c.mem_mask = mask;
            end
            7'h63: begin
                if (f3 == 3'b000) begin
                    taken = (a == b);
                end else if (f3 == 3'b001) begin
                    taken = (a != b);
                end else begin
                    taken = ($signed(a) >= $signed(b));
                end
                if (taken) begin
                    next = m_pc + imm_b;
                end
            end
            // ebreak, nothing changes
            default: wen = 1'b0;
        endcase
        c.reg_wen = wen;
        c.rd = rd;
        c.wdata = w;
        if (wen && rd != 5'd0) begin
            m_regs[rd] = w;
        end
        m_pc = next;
        return c;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("FAIL t=%0t pc=%h %s got %h expected %h", $time, commit.pc, name, got, want);
            errors++;
        end
    endtask

    // compare each retired instruction against the model
    always @(negedge clk) begin : commit_check
        commit_t want;
        if (reset === 1'b0) begin
            if (after_ebreak) begin
                assert (halted === 1'b1) else begin
                    $display("halted did not rise after ebreak retired, time %0t", $time);
                    errors++;
                end
            end
            after_ebreak = 1'b0;
            assert (!(halted && commit.valid)) else begin
                $display("a valid commit appeared after the core halted, time %0t", $time);
                errors++;
            end
            if (commit.valid === 1'b1) begin
                want = step_model();
                n_commits++;
                check_field("pc", commit.pc, want.pc);
                check_field("inst", commit.inst, want.inst);
                check_field("reg_wen", 32'(commit.reg_wen), 32'(want.reg_wen));
                if (want.reg_wen) begin
                    check_field("rd", 32'(commit.rd), 32'(want.rd));
                    check_field("wdata", commit.wdata, want.wdata);
                end
                check_field("mem_wen", 32'(commit.mem_wen), 32'(want.mem_wen));
                check_field("mem_mask", 32'(commit.mem_mask), 32'(want.mem_mask));
                if (want.mem_wen) begin
                    check_field("mem_addr", commit.mem_addr, want.mem_addr);
                    check_field("mem_wdata", commit.mem_wdata, want.mem_wdata);
                end
                if (commit.inst == ebreak_word) begin
                    ebreak_count++;
                    after_ebreak = 1'b1;
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = 32'd0;
        prog_data = 32'd0;
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = 32'd0;
        end
        build_program();
        // load, run, and some slack
        limit = prog.size() * 4 + 50;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        // fill instruction memory with the core stopped
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= i;
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        run <= 1'b1;
        while (halted !== 1'b1 && cycles < limit) begin
            @(posedge clk);
        end
        if (halted !== 1'b1) begin
            $display("timeout, halted was never reached within %0d cycles", limit);
            errors++;
        end
        // idle a few cycles to catch stray commits
        repeat (5) @(posedge clk);
        assert (ebreak_count == 1) else begin
            $display("ebreak retired %0d times instead of once", ebreak_count);
            errors++;
        end
        $display("%0d checks over %0d commits, %0d errors", checks, n_commits, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/npc.sv ====
module npc #(
    parameter logic [31:0] RESET_PC   = npc_pkg::RESET_PC_DEFAULT,
    parameter int unsigned IMEM_WORDS = npc_pkg::IMEM_WORDS_DEFAULT,
    parameter int unsigned DMEM_WORDS = npc_pkg::DMEM_WORDS_DEFAULT
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    input  logic             prog_we,
    input  logic [31:0]      prog_addr,
    input  logic [31:0]      prog_data,
    output logic             halted,
    output npc_pkg::commit_t commit
);
    import npc_pkg::*;

    localparam int unsigned imem_aw = $clog2(IMEM_WORDS);

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] pc_offset;
    logic [31:0] inst;
    logic        active;
    logic        reg_wen;
    logic        mem_wen;
    decoded_t    dec;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic        take_jump;
    logic [31:0] jump_target;
    logic [31:0] next_pc;

    // one retire per clock while running and neither in reset nor stopped
    assign active = run & ~halted & ~reset;
    assign reg_wen = active & dec.reg_wen;
    assign mem_wen = active & dec.mem_wen;

    // prog_addr is a word index into the instruction memory
    always_ff @(posedge clk) begin
        if (prog_we && !run) begin
            imem[prog_addr[imem_aw-1:0]] <= prog_data;
        end
    end

    // fetch relative to the reset vector
    assign pc_offset = pc - RESET_PC;
    assign inst = imem[pc_offset[imem_aw+1:2]];
    assign pc_plus4 = pc + 32'd4;

    inst_decode u_inst_decode (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .wen    (reg_wen),
        .waddr  (dec.rd),
        .wdata  (wb_data),
        .raddr1 (dec.rs1),
        .rdata1 (src1),
        .raddr2 (dec.rs2),
        .rdata2 (src2)
    );

    // auipc takes pc as the first operand
    assign alu_a = dec.src1_is_pc ? pc : src1;
    // immediates replace rs2
    assign alu_b = dec.src2_is_imm ? dec.imm : src2;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    branch_unit u_branch_unit (
        .pc          (pc),
        .src1        (src1),
        .src2        (src2),
        .dec         (dec),
        .take_jump   (take_jump),
        .jump_target (jump_target)
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .clk                (clk),
        .wen                (mem_wen),
        .ren                (dec.mem_ren),
        .addr               (alu_result),
        .wdata              (src2),
        .size               (dec.mem_size),
        .load_unsigned_byte (dec.load_unsigned_byte),
        .rdata              (load_data)
    );

    // write-back and next pc merge
    assign wb_data = dec.wb_from_mem ? load_data :
                     dec.wb_from_pc4 ? pc_plus4 : alu_result;
    assign next_pc = take_jump ? jump_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
            halted <= 1'b0;
        end else if (active) begin
            pc <= next_pc;
            // sticky until reset
            if (dec.is_ebreak) begin
                halted <= 1'b1;
            end
        end
    end

    // trace of the instruction retiring this cycle
    always_comb begin
        commit.valid = active;
        commit.pc = pc;
        commit.inst = inst;
        commit.reg_wen = reg_wen;
        commit.rd = dec.rd;
        commit.wdata = wb_data;
        commit.mem_wen = mem_wen;
        commit.mem_addr = alu_result;
        // data and mask as they land in the word
        commit.mem_wdata = store_lane(src2, dec.mem_size, alu_result[1:0]);
        commit.mem_mask = mem_wen ? store_mask(dec.mem_size, alu_result[1:0]) : 4'b0;
    end

endmodule

// ==== hw/data_mem.sv ====
module data_mem #(
    parameter int unsigned DMEM_WORDS = npc_pkg::DMEM_WORDS_DEFAULT
) (
    input  logic               clk,
    input  logic               wen,
    input  logic               ren,
    input  logic [31:0]        addr,
    input  logic [31:0]        wdata,
    input  npc_pkg::mem_size_e size,
    input  logic               load_unsigned_byte,
    output logic [31:0]        rdata
);
    import npc_pkg::*;

    localparam int unsigned idx_w = $clog2(DMEM_WORDS);

    logic [31:0]      mem [DMEM_WORDS];
    logic [idx_w-1:0] idx;
    logic [3:0]       mask;
    logic [31:0]      lane_data;
    logic [31:0]      rd_word;
    logic [7:0]       byte_sel;

    // word index, wraps at the depth
    assign idx = addr[idx_w+1:2];
    assign mask = store_mask(size, addr[1:0]);
    assign lane_data = store_lane(wdata, size, addr[1:0]);

    // byte-masked store
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) begin
                    mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

    // same-cycle read
    assign rd_word = mem[idx];
    assign byte_sel = rd_word[{addr[1:0], 3'b000} +: 8];

    // lbu zero-extends, lw returns the word
    assign rdata = !ren ? 32'b0 :
                   load_unsigned_byte ? {24'b0, byte_sel} : rd_word;

endmodule

// ==== hw/branch_unit.sv ====
module branch_unit (
    input  logic [31:0]       pc,
    input  logic [31:0]       src1,
    input  logic [31:0]       src2,
    input  npc_pkg::decoded_t dec,
    output logic              take_jump,
    output logic [31:0]       jump_target
);
    import npc_pkg::*;

    logic        equal;
    logic        greater_eq;
    logic        cond_met;
    logic [31:0] jalr_sum;

    // comparisons on the raw register values
    assign equal = (src1 == src2);
    assign greater_eq = ($signed(src1) >= $signed(src2));

    always_comb begin
        case (dec.branch_funct)
            br_eq:   cond_met = equal;
            br_ne:   cond_met = !equal;
            br_ge:   cond_met = greater_eq;
            default: cond_met = 1'b0;
        endcase
    end

    // jumps always leave, branches only when the compare holds
    assign take_jump = dec.is_jal | dec.is_jalr | (dec.is_branch & cond_met);

    // own adder, alu busy with the operands
    assign jalr_sum = src1 + dec.imm;
    // jalr clears bit 0
    assign jump_target = dec.is_jalr ? {jalr_sum[31:1], 1'b0} : pc + dec.imm;

endmodule

// ==== hw/alu.sv ====
module alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  npc_pkg::alu_op_e op,
    output logic [31:0]     result
);
    import npc_pkg::*;

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_xor: result = a ^ b;
            alu_or:  result = a | b;
            alu_and: result = a & b;
            alu_sll: result = a << shamt;
            // unsigned compare, 0 or 1
            alu_sltu: result = {31'b0, a < b};
            // arithmetic, sign bit fills from the left
            alu_sra: result = $unsigned($signed(a) >>> shamt);
            // lui path
            alu_pass_b: result = b;
            default: result = a + b;
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
    input  logic        clk,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    // x0 never written
    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

// ==== hw/inst_decode.sv ====
module inst_decode (
    input  logic [31:0]       inst,
    output npc_pkg::decoded_t dec
);
    import npc_pkg::*;

    // ebreak is matched on the whole word
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // sign-extended immediates per format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec = '0;
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.rd = inst[11:7];
        dec.alu_op = alu_add;
        dec.mem_size = size_word;
        dec.branch_funct = br_eq;
        case (opcode)
            opc_lui: begin
                // immediate passes straight through the alu
                dec.imm = imm_u;
                dec.alu_op = alu_pass_b;
                dec.src2_is_imm = 1'b1;
                dec.reg_wen = 1'b1;
            end
            opc_auipc: begin
                dec.imm = imm_u;
                dec.src1_is_pc = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.reg_wen = 1'b1;
            end
            opc_op: begin
                dec.reg_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = alu_add;
                    {7'b0100000, 3'b000}: dec.alu_op = alu_sub;
                    {7'b0000000, 3'b100}: dec.alu_op = alu_xor;
                    {7'b0000000, 3'b110}: dec.alu_op = alu_or;
                    {7'b0000000, 3'b111}: dec.alu_op = alu_and;
                    {7'b0000000, 3'b001}: dec.alu_op = alu_sll;
                    {7'b0000000, 3'b011}: dec.alu_op = alu_sltu;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opc_op_imm: begin
                dec.imm = imm_i;
                dec.src2_is_imm = 1'b1;
                dec.reg_wen = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = alu_add;
                    3'b100: dec.alu_op = alu_xor;
                    3'b111: dec.alu_op = alu_and;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b101: begin
                        // only srai, srli is outside the subset
                        dec.alu_op = alu_sra;
                        dec.illegal = (funct7 != 7'b0100000);
                    end
                    default: dec.illegal = 1'b1;
                endcase
            end
            opc_load: begin
                // address is rs1 + imm through the alu
                dec.imm = imm_i;
                dec.src2_is_imm = 1'b1;
                dec.reg_wen = 1'b1;
                dec.wb_from_mem = 1'b1;
                dec.mem_ren = 1'b1;
                case (funct3)
                    3'b010: dec.mem_size = size_word;
                    3'b100: begin
                        dec.mem_size = size_byte;
                        dec.load_unsigned_byte = 1'b1;
                    end
                    default: dec.illegal = 1'b1;
                endcase
            end
            opc_store: begin
                dec.imm = imm_s;
                dec.src2_is_imm = 1'b1;
                dec.mem_wen = 1'b1;
                case (funct3)
                    3'b000: dec.mem_size = size_byte;
                    3'b001: dec.mem_size = size_half;
                    3'b010: dec.mem_size = size_word;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opc_branch: begin
                dec.imm = imm_b;
                dec.is_branch = 1'b1;
                case (funct3)
                    3'b000: dec.branch_funct = br_eq;
                    3'b001: dec.branch_funct = br_ne;
                    3'b101: dec.branch_funct = br_ge;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opc_jal: begin
                dec.imm = imm_j;
                dec.is_jal = 1'b1;
                dec.reg_wen = 1'b1;
                dec.wb_from_pc4 = 1'b1;
            end
            opc_jalr: begin
                dec.imm = imm_i;
                dec.is_jalr = 1'b1;
                dec.reg_wen = 1'b1;
                dec.wb_from_pc4 = 1'b1;
                dec.illegal = (funct3 != 3'b000);
            end
            opc_system: begin
                dec.is_ebreak = (inst == ebreak_word);
                dec.illegal = (inst != ebreak_word);
            end
            default: dec.illegal = 1'b1;
        endcase
        // illegal words retire with no side effects
        if (dec.illegal) begin
            dec.reg_wen = 1'b0;
            dec.mem_ren = 1'b0;
            dec.mem_wen = 1'b0;
            dec.is_branch = 1'b0;
            dec.is_jal = 1'b0;
            dec.is_jalr = 1'b0;
        end
    end

endmodule

// ==== hw/npc_pkg.sv ====
package npc_pkg;

    // reset vector and memory depths, overridden from npc
    localparam logic [31:0] RESET_PC_DEFAULT   = 32'h8000_0000;
    localparam int unsigned IMEM_WORDS_DEFAULT = 256;
    localparam int unsigned DMEM_WORDS_DEFAULT = 256;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_sltu,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    // access width of loads and stores
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    // branch compare kinds
    typedef enum logic [1:0] {
        br_eq,
        br_ne,
        br_ge
    } branch_funct_e;

    typedef struct packed {
        logic [4:0]    rs1;
        logic [4:0]    rs2;
        logic [4:0]    rd;
        logic [31:0]   imm;
        alu_op_e       alu_op;
        logic          src1_is_pc;
        logic          src2_is_imm;
        logic          reg_wen;
        logic          wb_from_mem;
        logic          wb_from_pc4;
        logic          mem_ren;
        logic          mem_wen;
        mem_size_e     mem_size;
        logic          load_unsigned_byte;
        logic          is_branch;
        branch_funct_e branch_funct;
        logic          is_jal;
        logic          is_jalr;
        logic          is_ebreak;
        logic          illegal;
    } decoded_t;

    // one retired instruction
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        reg_wen;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        mem_wen;
        logic [31:0] mem_addr;
        logic [31:0] mem_wdata;
        logic [3:0]  mem_mask;
    } commit_t;

    // byte enables within the word, low address bits truncated to the size
    function automatic logic [3:0] store_mask(input mem_size_e size, input logic [1:0] offset);
        case (size)
            size_byte: return 4'b0001 << offset;
            size_half: return 4'b0011 << {offset[1], 1'b0};
            default:   return 4'b1111;
        endcase
    endfunction

    // store data moved into its byte lane
    function automatic logic [31:0] store_lane(input logic [31:0] data, input mem_size_e size,
                                               input logic [1:0] offset);
        case (size)
            size_byte: return {24'b0, data[7:0]} << {offset, 3'b000};
            size_half: return {16'b0, data[15:0]} << {offset[1], 4'b0000};
            default:   return data;
        endcase
    endfunction

endpackage
